// ==== include/chip_config.svh ====
/*
  Sizes and constants of the pad wrapper.
  RT_CLK_DIV must be even. CDC_SYNC_STAGES should stay at 2 or more.
*/
`ifndef CHIP_CONFIG_SVH
`define CHIP_CONFIG_SVH

//////////////////////////////
// pad bank
//////////////////////////////

`define NUM_MUXED_PADS 8

//////////////////////////////
// configuration bus
//////////////////////////////

`define CFG_ADDR_W 8
`define CFG_DATA_W 32

// flops on req before the fsm sees it
`define CDC_SYNC_STAGES 2

//////////////////////////////
// real-time clock
//////////////////////////////

// output period in reference cycles
`define RT_CLK_DIV 10

`endif

// ==== list.f ====
+incdir+include
verilog/pad_pkg.sv
verilog/cfg_pkg.sv
verilog/rt_clk_div.sv
verilog/reg_cdc_dst.sv
verilog/pad_mux_cfg.sv
verilog/pad_mux.sv
verilog/chip_wrap.sv
verification/tb_clk_gen.sv
verification/chip_wrap_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, pass only if TEST OK is printed
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f list.f --top-module chip_wrap_tb \
       --Mdir obj_dir -o chip_wrap_tb_sim \
  && ./obj_dir/chip_wrap_tb_sim | tee /dev/stderr | grep -qx "TEST OK" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== verification/chip_wrap_tb.sv ====
/*
  Directed tests of the pad wrapper. Inputs change on the rising edge, outputs are
  sampled on the falling edge. Any error stops the run at once.
*/
`timescale 1ns/1ps
`include "chip_config.svh"

module chip_wrap_tb;

  import cfg_pkg::*;
  import pad_pkg::*;

  localparam int unsigned ack_wait_cycles  = `CDC_SYNC_STAGES + 8;
  localparam int unsigned handshake_cycles = 2 * ack_wait_cycles + 4;
  localparam int unsigned max_handshakes   = 64;
  localparam int unsigned half_div         = `RT_CLK_DIV / 2;
  localparam int unsigned phase_limit      = `RT_CLK_DIV + 2;
  localparam int unsigned rt_phases        = 8;
  localparam int unsigned drive_cycles     = 64;
  localparam int unsigned watchdog_cycles  = 2 * (10 + max_handshakes * handshake_cycles
                                             + (rt_phases + 1) * phase_limit + drive_cycles);
  localparam logic [31:0] lfsr_taps        = 32'h8020_0003;

  logic                       clk;
  logic                       reset;
  logic                       cfg_req;
  cfg_req_t                   cfg_data;
  logic                       cfg_ack;
  cfg_rsp_t                   cfg_rsp;
  soc2pad_t                   soc2pad;
  pad2soc_t                   pad2soc;
  logic [`NUM_MUXED_PADS-1:0] pad_in;
  pad_out_t                   pad_drive;
  logic                       rt_clk;
  logic [31:0]                lfsr_state;

  tb_clk_gen u_clk_gen (
    .clk_o   ( clk   ),
    .reset_o ( reset )
  );

  chip_wrap u_dut (
    .ref_clk_i  ( clk       ),
    .reset_i    ( reset     ),
    .cfg_req_i  ( cfg_req   ),
    .cfg_data_i ( cfg_data  ),
    .cfg_ack_o  ( cfg_ack   ),
    .cfg_rsp_o  ( cfg_rsp   ),
    .soc2pad_i  ( soc2pad   ),
    .pad2soc_o  ( pad2soc   ),
    .pad_i      ( pad_in    ),
    .pad_o      ( pad_drive ),
    .rt_clk_o   ( rt_clk    )
  );

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // galois lfsr, one step per bit
  task automatic rand_bits(input int unsigned count, output logic [31:0] value);
    logic lsb;
    value = '0;
    for (int unsigned i = 0; i < count; i++) begin
      lsb        = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) begin
        lfsr_state = lfsr_state ^ lfsr_taps;
      end
      value = {value[30:0], lsb};
    end
  endtask

  task automatic wait_ack(input logic level);
    int unsigned n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (cfg_ack !== level && n < ack_wait_cycles);
    if (cfg_ack !== level) begin
      abort_run($sformatf("cfg_ack_o did not reach %0d within %0d cycles", level,
                          ack_wait_cycles));
    end
  endtask

  // data first, then req, response taken while ack is high
  task automatic four_phase(input cfg_op_e op, input logic [`CFG_ADDR_W-1:0] addr,
                            input logic [`CFG_DATA_W-1:0] wdata, output cfg_rsp_t rsp);
    @(posedge clk);
    cfg_data.op    <= op;
    cfg_data.addr  <= addr;
    cfg_data.wdata <= wdata;
    @(posedge clk);
    cfg_req <= 1'b1;
    wait_ack(1'b1);
    rsp = cfg_rsp;
    @(posedge clk);
    cfg_req <= 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic write_reg(input int unsigned addr, input logic [31:0] wdata,
                           output cfg_rsp_t rsp);
    four_phase(OP_WRITE, `CFG_ADDR_W'(addr), wdata, rsp);
  endtask

  task automatic read_reg(input int unsigned addr, output cfg_rsp_t rsp);
    four_phase(OP_READ, `CFG_ADDR_W'(addr), '0, rsp);
  endtask

  task automatic set_all_pads(input pad_func_e func);
    cfg_rsp_t rsp;
    for (int unsigned k = 0; k < `NUM_MUXED_PADS; k++) begin
      write_reg(k, 32'(func), rsp);
      check_value("cfg_rsp_o.error", 32'(rsp.error), 32'h0);
    end
  endtask

  task automatic count_phase(output int unsigned cycles);
    logic level;
    level  = rt_clk;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (rt_clk == level && cycles < phase_limit);
    if (rt_clk == level) begin
      abort_run("rt_clk_o stopped toggling");
    end
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic reset_state();
    check_value("pad_o.pad_oe", 32'(pad_drive.pad_oe), 32'h0);
    check_value("cfg_ack_o", 32'(cfg_ack), 32'h0);
    check_value("cfg_rsp_o.rdata", 32'(cfg_rsp.rdata), 32'h0);
    check_value("cfg_rsp_o.error", 32'(cfg_rsp.error), 32'h0);
    check_value("rt_clk_o", 32'(rt_clk), 32'h0);
  endtask

  task automatic config_access();
    logic [31:0] r;
    logic [1:0]  exp_func [`NUM_MUXED_PADS];
    cfg_rsp_t    rsp;
    for (int unsigned k = 0; k < `NUM_MUXED_PADS; k++) begin
      rand_bits(2, r);
      exp_func[k] = r[1:0];
      write_reg(k, r, rsp);
      check_value("cfg_rsp_o.error", 32'(rsp.error), 32'h0);
    end
    for (int unsigned k = 0; k < `NUM_MUXED_PADS; k++) begin
      read_reg(k, rsp);
      check_value("cfg_rsp_o.rdata", rsp.rdata, 32'(exp_func[k]));
      check_value("cfg_rsp_o.error", 32'(rsp.error), 32'h0);
    end
    // first address past the pad bank, its low bits alias pad 0
    write_reg(`NUM_MUXED_PADS, {30'h3fff_ffff, ~exp_func[0]}, rsp);
    check_value("cfg_rsp_o.error", 32'(rsp.error), 32'h1);
    check_value("cfg_rsp_o.rdata", rsp.rdata, 32'h0);
    read_reg(`NUM_MUXED_PADS, rsp);
    check_value("cfg_rsp_o.error", 32'(rsp.error), 32'h1);
    check_value("cfg_rsp_o.rdata", rsp.rdata, 32'h0);
    for (int unsigned k = 0; k < `NUM_MUXED_PADS; k++) begin
      read_reg(k, rsp);
      check_value("cfg_rsp_o.rdata", rsp.rdata, 32'(exp_func[k]));
    end
  endtask

  task automatic gpio_routing();
    logic [31:0] g_out;
    logic [31:0] g_oe;
    logic [31:0] p_in;
    set_all_pads(FUNC_GPIO);
    repeat (4) begin
      rand_bits(`NUM_MUXED_PADS, g_out);
      rand_bits(`NUM_MUXED_PADS, g_oe);
      rand_bits(`NUM_MUXED_PADS, p_in);
      @(posedge clk);
      soc2pad.gpio_out <= g_out[`NUM_MUXED_PADS-1:0];
      soc2pad.gpio_oe  <= g_oe[`NUM_MUXED_PADS-1:0];
      pad_in           <= p_in[`NUM_MUXED_PADS-1:0];
      @(negedge clk);
      check_value("pad_o.pad_out", 32'(pad_drive.pad_out), g_out);
      check_value("pad_o.pad_oe", 32'(pad_drive.pad_oe), g_oe);
      check_value("pad2soc_o.gpio_in", 32'(pad2soc.gpio_in), p_in);
    end
  endtask

  task automatic uart_spi_routing();
    logic [31:0]                r;
    logic [`NUM_MUXED_PADS-1:0] exp_out;
    cfg_rsp_t                   rsp;
    set_all_pads(FUNC_OFF);
    check_value("pad2soc_o.uart_rx", 32'(pad2soc.uart_rx), 32'h1);
    write_reg(2, 32'(FUNC_UART), rsp);
    write_reg(5, 32'(FUNC_UART), rsp);
    repeat (4) begin
      rand_bits(`NUM_MUXED_PADS + 1, r);
      @(posedge clk);
      soc2pad.uart_tx <= r[`NUM_MUXED_PADS];
      pad_in          <= r[`NUM_MUXED_PADS-1:0];
      @(negedge clk);
      exp_out    = '0;
      exp_out[2] = r[`NUM_MUXED_PADS];
      exp_out[5] = r[`NUM_MUXED_PADS];
      check_value("pad_o.pad_out", 32'(pad_drive.pad_out), 32'(exp_out));
      check_value("pad_o.pad_oe", 32'(pad_drive.pad_oe), 32'h24);
      check_value("pad2soc_o.uart_rx", 32'(pad2soc.uart_rx), 32'(r[2]));
      // no gpio and no spi pad selected
      check_value("pad2soc_o.gpio_in", 32'(pad2soc.gpio_in), 32'h0);
      check_value("pad2soc_o.spi_miso", 32'(pad2soc.spi_miso), 32'h0);
    end
    write_reg(2, 32'(FUNC_OFF), rsp);
    write_reg(5, 32'(FUNC_OFF), rsp);
    check_value("pad2soc_o.uart_rx", 32'(pad2soc.uart_rx), 32'h1);
    for (int unsigned k = 0; k < 4; k++) begin
      write_reg(k, 32'(FUNC_SPI), rsp);
    end
    repeat (4) begin
      rand_bits(`NUM_MUXED_PADS + 3, r);
      @(posedge clk);
      soc2pad.spi_sck  <= r[`NUM_MUXED_PADS];
      soc2pad.spi_csb  <= r[`NUM_MUXED_PADS+1];
      soc2pad.spi_mosi <= r[`NUM_MUXED_PADS+2];
      pad_in           <= r[`NUM_MUXED_PADS-1:0];
      @(negedge clk);
      exp_out    = '0;
      exp_out[0] = r[`NUM_MUXED_PADS];
      exp_out[1] = r[`NUM_MUXED_PADS+1];
      exp_out[2] = r[`NUM_MUXED_PADS+2];
      check_value("pad_o.pad_out", 32'(pad_drive.pad_out), 32'(exp_out));
      check_value("pad_o.pad_oe", 32'(pad_drive.pad_oe), 32'h07);
      check_value("pad2soc_o.spi_miso", 32'(pad2soc.spi_miso), 32'(r[3]));
    end
    // sck held high so an off pad shows a real change
    @(posedge clk);
    soc2pad.spi_sck <= 1'b1;
    write_reg(0, 32'(FUNC_OFF), rsp);
    check_value("pad_o.pad_out[0]", 32'(pad_drive.pad_out[0]), 32'h0);
    check_value("pad_o.pad_oe", 32'(pad_drive.pad_oe), 32'h06);
  endtask

  task automatic rt_clock_period();
    int unsigned cycles;
    // first phase is partial
    count_phase(cycles);
    for (int unsigned i = 0; i < rt_phases; i++) begin
      count_phase(cycles);
      check_value("rt_clk_o half period", 32'(cycles), 32'(half_div));
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    lfsr_state = 32'ha831;
    cfg_req    = 1'b0;
    cfg_data   = '0;
    soc2pad    = '0;
    pad_in     = '0;
    @(negedge clk);
    while (reset) begin
      @(negedge clk);
    end
    reset_state();
    config_access();
    gpio_routing();
    uart_spi_routing();
    rt_clock_period();
    $display("TEST OK");
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    abort_run($sformatf("watchdog expired after %0d cycles", watchdog_cycles));
  end

endmodule

// ==== verification/tb_clk_gen.sv ====
/*
  Testbench clock and reset, 4 ns period.
  Reset is high for the first 5 rising edges.
*/
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (5) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// ==== verilog/cfg_pkg.sv ====
/*
  Configuration bus types and the state type of the req/ack crossing.
*/
`include "chip_config.svh"

package cfg_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cfg_op_e;

  typedef struct packed {
    cfg_op_e                op;
    logic [`CFG_ADDR_W-1:0] addr;
    logic [`CFG_DATA_W-1:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic [`CFG_DATA_W-1:0] rdata;
    logic                   error;
  } cfg_rsp_t;

  // destination side of the four-phase handshake
  typedef enum logic [1:0] {
    IDLE     = 2'd0,
    ACCESS   = 2'd1,
    ACK_HIGH = 2'd2
  } cdc_state_e;

endpackage

// ==== verilog/chip_wrap.sv ====
/*
  Pad-side wrapper, everything in the ref_clk_i domain with synchronous reset_i.
  Pads are split into in, out and output-enable vectors; no inout.
  A select write reaches the pads in the cycle cfg_ack_o rises.
*/
`timescale 1ns/1ps
`include "chip_config.svh"

module chip_wrap (
  input  logic                       ref_clk_i,
  input  logic                       reset_i,
  input  logic                       cfg_req_i,
  input  cfg_pkg::cfg_req_t          cfg_data_i,
  output logic                       cfg_ack_o,
  output cfg_pkg::cfg_rsp_t          cfg_rsp_o,
  input  pad_pkg::soc2pad_t          soc2pad_i,
  output pad_pkg::pad2soc_t          pad2soc_o,
  input  logic [`NUM_MUXED_PADS-1:0] pad_i,
  output pad_pkg::pad_out_t          pad_o,
  output logic                       rt_clk_o
);

  import cfg_pkg::*;
  import pad_pkg::*;

  logic      access_valid;
  cfg_req_t  access_req;
  cfg_rsp_t  access_rsp;
  pad_func_e pad_func [`NUM_MUXED_PADS];

  rt_clk_div u_rt_clk_div (
    .clk_i    ( ref_clk_i ),
    .reset_i  ( reset_i   ),
    .rt_clk_o ( rt_clk_o  )
  );

  //////////////////////////////
  // configuration path
  //////////////////////////////

  reg_cdc_dst u_reg_cdc_dst (
    .clk_i          ( ref_clk_i    ),
    .reset_i        ( reset_i      ),
    .async_req_i    ( cfg_req_i    ),
    .async_data_i   ( cfg_data_i   ),
    .async_ack_o    ( cfg_ack_o    ),
    .async_rsp_o    ( cfg_rsp_o    ),
    .access_valid_o ( access_valid ),
    .access_req_o   ( access_req   ),
    .access_rsp_i   ( access_rsp   )
  );

  pad_mux_cfg u_pad_mux_cfg (
    .clk_i          ( ref_clk_i    ),
    .reset_i        ( reset_i      ),
    .access_valid_i ( access_valid ),
    .access_req_i   ( access_req   ),
    .access_rsp_o   ( access_rsp   ),
    .pad_func_o     ( pad_func     )
  );

  pad_mux u_pad_mux (
    .pad_func_i ( pad_func  ),
    .soc2pad_i  ( soc2pad_i ),
    .pad2soc_o  ( pad2soc_o ),
    .pad_i      ( pad_i     ),
    .pad_o      ( pad_o     )
  );

endmodule

// ==== verilog/pad_mux.sv ====
/*
  Combinational routing between SoC functions and the muxed pads.
  SPI role of a pad is fixed by its index mod 4 (sck, csb, mosi, miso).
  uart_rx and spi_miso come from the lowest-index pad with that function.
*/
`timescale 1ns/1ps
`include "chip_config.svh"

module pad_mux (
  input  pad_pkg::pad_func_e          pad_func_i [`NUM_MUXED_PADS],
  input  pad_pkg::soc2pad_t           soc2pad_i,
  output pad_pkg::pad2soc_t           pad2soc_o,
  input  logic [`NUM_MUXED_PADS-1:0]  pad_i,
  output pad_pkg::pad_out_t           pad_o
);

  import pad_pkg::*;

  // walk down so the lowest matching pad is assigned last and wins
  always_comb begin
    pad_o             = '0;
    pad2soc_o         = '0;
    pad2soc_o.uart_rx = 1'b1;
    for (int k = `NUM_MUXED_PADS - 1; k >= 0; k--) begin
      case (pad_func_i[k])
        FUNC_GPIO: begin
          pad_o.pad_out[k]     = soc2pad_i.gpio_out[k];
          pad_o.pad_oe[k]      = soc2pad_i.gpio_oe[k];
          pad2soc_o.gpio_in[k] = pad_i[k];
        end
        FUNC_UART: begin
          pad_o.pad_out[k]  = soc2pad_i.uart_tx;
          pad_o.pad_oe[k]   = 1'b1;
          pad2soc_o.uart_rx = pad_i[k];
        end
        FUNC_SPI: begin
          case (k % 4)
            0: begin
              pad_o.pad_out[k] = soc2pad_i.spi_sck;
              pad_o.pad_oe[k]  = 1'b1;
            end
            1: begin
              pad_o.pad_out[k] = soc2pad_i.spi_csb;
              pad_o.pad_oe[k]  = 1'b1;
            end
            2: begin
              pad_o.pad_out[k] = soc2pad_i.spi_mosi;
              pad_o.pad_oe[k]  = 1'b1;
            end
            default: begin
              // input only, oe stays low
              pad2soc_o.spi_miso = pad_i[k];
            end
          endcase
        end
        default: begin
          pad_o.pad_out[k] = 1'b0;
          pad_o.pad_oe[k]  = 1'b0;
        end
      endcase
    end
  end

endmodule

// ==== verilog/pad_mux_cfg.sv ====
/*
  Function select registers of the muxed pads, one per pad at address k.
  Data bits [1:0] hold the function, upper bits read zero.
  Addresses at or above NUM_MUXED_PADS answer with error and ignore writes.
*/
`timescale 1ns/1ps
`include "chip_config.svh"

module pad_mux_cfg (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                access_valid_i,
  input  cfg_pkg::cfg_req_t   access_req_i,
  output cfg_pkg::cfg_rsp_t   access_rsp_o,
  output pad_pkg::pad_func_e  pad_func_o [`NUM_MUXED_PADS]
);

  import cfg_pkg::*;
  import pad_pkg::*;

  localparam int unsigned sel_w = $clog2(`NUM_MUXED_PADS);

  pad_func_e        pad_func_q [`NUM_MUXED_PADS];
  logic             addr_hit;
  logic [sel_w-1:0] sel;
  logic             wr_en;

  //////////////////////////////
  // address decode
  //////////////////////////////

  assign addr_hit = access_req_i.addr < `CFG_ADDR_W'(`NUM_MUXED_PADS);
  assign sel      = access_req_i.addr[sel_w-1:0];
  assign wr_en    = access_valid_i && (access_req_i.op == OP_WRITE) && addr_hit;

  // everything off out of reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int k = 0; k < `NUM_MUXED_PADS; k++) begin
        pad_func_q[k] <= FUNC_OFF;
      end
    end else if (wr_en) begin
      pad_func_q[sel] <= pad_func_e'(access_req_i.wdata[1:0]);
    end
  end

  //////////////////////////////
  // read data and error
  //////////////////////////////

  always_comb begin
    access_rsp_o = '0;
    if (addr_hit) begin
      access_rsp_o.rdata[1:0] = pad_func_q[sel];
    end else begin
      access_rsp_o.error = 1'b1;
    end
  end

  assign pad_func_o = pad_func_q;

endmodule

// ==== verilog/pad_pkg.sv ====
/*
  Types of the muxed pad bank.
  Vector widths follow NUM_MUXED_PADS; bit k of every vector belongs to pad k.
*/
`include "chip_config.svh"

package pad_pkg;

  // function of one pad, as stored in its select register
  typedef enum logic [1:0] {
    FUNC_OFF  = 2'd0,
    FUNC_GPIO = 2'd1,
    FUNC_UART = 2'd2,
    FUNC_SPI  = 2'd3
  } pad_func_e;

  // function outputs from the SoC
  typedef struct packed {
    logic [`NUM_MUXED_PADS-1:0] gpio_out;
    logic [`NUM_MUXED_PADS-1:0] gpio_oe;
    logic                       uart_tx;
    logic                       spi_sck;
    logic                       spi_csb;
    logic                       spi_mosi;
  } soc2pad_t;

  // function inputs to the SoC
  typedef struct packed {
    logic [`NUM_MUXED_PADS-1:0] gpio_in;
    logic                       uart_rx;
    logic                       spi_miso;
  } pad2soc_t;

  // what goes to the pad cells
  typedef struct packed {
    logic [`NUM_MUXED_PADS-1:0] pad_out;
    logic [`NUM_MUXED_PADS-1:0] pad_oe;
  } pad_out_t;

endpackage

// ==== verilog/reg_cdc_dst.sv ====
/*
  Destination half of a four-phase req/ack crossing, one register access per handshake.
  The source holds async_data_i from req rise to ack rise and raises req only while ack
  is low. Response is valid while async_ack_o is high.
*/
`timescale 1ns/1ps
`include "chip_config.svh"

module reg_cdc_dst (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              async_req_i,
  input  cfg_pkg::cfg_req_t async_data_i,
  output logic              async_ack_o,
  output cfg_pkg::cfg_rsp_t async_rsp_o,
  output logic              access_valid_o,
  output cfg_pkg::cfg_req_t access_req_o,
  input  cfg_pkg::cfg_rsp_t access_rsp_i
);

  import cfg_pkg::*;

  logic [`CDC_SYNC_STAGES-1:0] req_sync_q;
  logic                        req_seen;
  cdc_state_e                  state_q;
  cfg_req_t                    req_q;
  cfg_rsp_t                    rsp_q;
  logic                        ack_q;

  //////////////////////////////
  // req synchronizer
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_sync_q <= '0;
    end else begin
      req_sync_q[0] <= async_req_i;
      for (int i = 1; i < `CDC_SYNC_STAGES; i++) begin
        req_sync_q[i] <= req_sync_q[i-1];
      end
    end
  end

  assign req_seen = req_sync_q[`CDC_SYNC_STAGES-1];

  //////////////////////////////
  // handshake fsm
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      ack_q   <= 1'b0;
      rsp_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (req_seen) begin
            state_q <= ACCESS;
          end
        end
        ACCESS: begin
          rsp_q   <= access_rsp_i;
          ack_q   <= 1'b1;
          state_q <= ACK_HIGH;
        end
        ACK_HIGH: begin
          // wait for the source to release req
          if (!req_seen) begin
            ack_q   <= 1'b0;
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // data is stable by the time req has passed the synchronizer
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_seen) begin
      req_q <= async_data_i;
    end
  end

  assign access_valid_o = (state_q == ACCESS);
  assign access_req_o   = req_q;
  assign async_ack_o    = ack_q;
  assign async_rsp_o    = rsp_q;

  a_ack_needs_req: assert property (
    @(posedge clk_i) disable iff (reset_i)
    $rose(ack_q) |-> req_seen
  ) else $error("ack rose while synchronized req was low");

  a_single_access: assert property (
    @(posedge clk_i) disable iff (reset_i)
    access_valid_o |=> !access_valid_o
  ) else $error("access strobe longer than one cycle");

endmodule

// ==== verilog/rt_clk_div.sv ====
/*
  Static divider for the real-time clock.
  Output is a flop, low out of reset, period RT_CLK_DIV input cycles, 50% duty.
*/
`timescale 1ns/1ps
`include "chip_config.svh"

module rt_clk_div (
  input  logic clk_i,
  input  logic reset_i,
  output logic rt_clk_o
);

  localparam int unsigned half_div = `RT_CLK_DIV / 2;
  localparam int unsigned cnt_w    = $clog2(half_div + 1);

  logic [cnt_w-1:0] cnt_q;
  logic             rt_clk_q;

  // toggle once per half period
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q    <= '0;
      rt_clk_q <= 1'b0;
    end else if (cnt_q == cnt_w'(half_div - 1)) begin
      cnt_q    <= '0;
      rt_clk_q <= ~rt_clk_q;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign rt_clk_o = rt_clk_q;

  a_cnt_in_range: assert property (
    @(posedge clk_i) disable iff (reset_i)
    cnt_q <= cnt_w'(half_div - 1)
  ) else $error("rt_clk_div counter past its wrap value");

endmodule
